/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

    // byte address as seen on both SRAM-like ports and on AR/AW
    typedef logic [31:0] addr_t;

    // one data word, read or write
    typedef logic [31:0] data_t;

    // one strobe bit per byte lane of data_t
    typedef logic [3:0] strb_t;

    // RAM geometry
    localparam int MEM_WORDS  = 1024;   // 4 KiB of words
    localparam int WORD_IDX_W = 10;     // log2(MEM_WORDS)

    // word index sits at addr[WORD_IDX_W+1:2]
    // everything above is ignored, so addresses wrap every 4 KiB
    // byte offset addr[1:0] is dropped, lanes come from the strobe

endpackage

/* hdl/sram_port_arbiter.sv */
`timescale 1ns/1ps

module sram_port_arbiter
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // fetch port, read only
    input  logic  inst_ce,
    input  addr_t inst_addr,
    output data_t inst_rdata,
    output logic  inst_rdata_valid,
    // data port
    input  logic  data_ce,
    input  logic  data_we,
    input  addr_t data_addr,
    input  data_t data_wdata,
    input  strb_t data_wmask,
    output data_t data_rdata,
    output logic  data_rdata_valid,
    output logic  data_write_finish,
    // towards the AXI master
    output logic  req_valid,
    output logic  req_we,
    output addr_t req_addr,
    output data_t req_wdata,
    output strb_t req_strb,
    input  logic  req_done,
    input  data_t req_rdata
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INST,
        OWN_DATA
    } owner_e;

    owner_e owner;   // who the master is working for

    // grant register, data port wins a tie (older instruction)
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= OWN_NONE;
        end else if (owner == OWN_NONE) begin
            if (data_ce) begin
                owner <= OWN_DATA;
            end else if (inst_ce) begin
                owner <= OWN_INST;
            end
        end else if (req_done) begin
            owner <= OWN_NONE;   // back to idle, waiting port picked next cycle
        end
    end

    // capture the winner's fields, held until req_done
    always_ff @(posedge clk) begin
        if (owner == OWN_NONE) begin
            if (data_ce) begin
                req_we    <= data_we;
                req_addr  <= data_addr;
                req_wdata <= data_wdata;
                req_strb  <= data_wmask;
            end else if (inst_ce) begin
                req_we    <= 1'b0;   // fetch only reads
                req_addr  <= inst_addr;
                req_wdata <= '0;
                req_strb  <= '0;
            end
        end
    end

    assign req_valid = (owner != OWN_NONE);

    // completions go straight back in the req_done cycle
    assign inst_rdata        = req_rdata;
    assign data_rdata        = req_rdata;
    assign inst_rdata_valid  = req_done && (owner == OWN_INST);
    assign data_rdata_valid  = req_done && (owner == OWN_DATA) && !req_we;
    assign data_write_finish = req_done && (owner == OWN_DATA) && req_we;

endmodule

/* hdl/axi_lite_master.sv */
`timescale 1ns/1ps

module axi_lite_master
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // request from the arbiter
    input  logic  req_valid,
    input  logic  req_we,
    input  addr_t req_addr,
    input  data_t req_wdata,
    input  strb_t req_strb,
    output logic  req_done,
    output data_t req_rdata,
    // AR channel
    output logic  ar_valid,
    input  logic  ar_ready,
    output addr_t ar_addr,
    // R channel
    input  logic  r_valid,
    output logic  r_ready,
    input  data_t r_data,
    // AW channel
    output logic  aw_valid,
    input  logic  aw_ready,
    output addr_t aw_addr,
    // W channel
    output logic  w_valid,
    input  logic  w_ready,
    output data_t w_data,
    output strb_t w_strb,
    // B channel
    input  logic  b_valid,
    output logic  b_ready
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_WR_REQ,
        ST_WR_RESP,
        ST_DONE
    } state_e;

    state_e state;
    logic   aw_done;   // AW already taken by the slave
    logic   w_done;    // W already taken by the slave
    logic   aw_ok;
    logic   w_ok;
    data_t  rdata_q;   // read word kept for the done pulse

    // accepted earlier or in this very cycle
    assign aw_ok = aw_done || (aw_valid && aw_ready);
    assign w_ok  = w_done || (w_valid && w_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (req_valid) begin
                        state <= req_we ? ST_WR_REQ : ST_RD_ADDR;
                    end
                end
                ST_RD_ADDR: if (ar_ready) state <= ST_RD_DATA;
                ST_RD_DATA: if (r_valid) state <= ST_DONE;
                ST_WR_REQ: begin
                    if (aw_ok && w_ok) begin
                        state   <= ST_WR_RESP;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else begin
                        aw_done <= aw_ok;   // AW and W may land in different cycles
                        w_done  <= w_ok;
                    end
                end
                ST_WR_RESP: if (b_valid) state <= ST_DONE;
                ST_DONE:    state <= ST_IDLE;   // single pulse then idle
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_valid && r_ready) begin
            rdata_q <= r_data;
        end
    end

    // channel controls straight from state
    assign ar_valid  = (state == ST_RD_ADDR);
    assign r_ready   = (state == ST_RD_DATA);
    assign aw_valid  = (state == ST_WR_REQ) && !aw_done;
    assign w_valid   = (state == ST_WR_REQ) && !w_done;
    assign b_ready   = (state == ST_WR_RESP);
    assign req_done  = (state == ST_DONE);
    assign req_rdata = rdata_q;

    // fields come straight from the arbiter's held request
    assign ar_addr = req_addr;
    assign aw_addr = req_addr;
    assign w_data  = req_wdata;
    assign w_strb  = req_strb;

endmodule

/* hdl/axi_lite_ram.sv */
`timescale 1ns/1ps

module axi_lite_ram
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // AR channel
    input  logic  ar_valid,
    output logic  ar_ready,
    input  addr_t ar_addr,
    // R channel
    output logic  r_valid,
    input  logic  r_ready,
    output data_t r_data,
    // AW channel
    input  logic  aw_valid,
    output logic  aw_ready,
    input  addr_t aw_addr,
    // W channel
    input  logic  w_valid,
    output logic  w_ready,
    input  data_t w_data,
    input  strb_t w_strb,
    // B channel
    output logic  b_valid,
    input  logic  b_ready
);

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_RD_RESP,
        RAM_WR_RESP
    } ram_state_e;

    data_t      mem [MEM_WORDS];
    ram_state_e state;
    logic       aw_got;    // address came before its data
    logic       w_got;     // data came before its address
    addr_t      awaddr_q;
    data_t      wdata_q;
    strb_t      wstrb_q;
    logic       aw_ok;
    logic       w_ok;
    logic       wr_fire;   // both halves present so the write lands now
    logic [WORD_IDX_W-1:0] wr_idx;
    data_t      wr_data;
    strb_t      wr_strb;

    wire idle = (state == RAM_IDLE);

    // a half-accepted write finishes before a read is let in
    assign ar_ready = idle && !aw_got && !w_got;
    assign aw_ready = idle && !aw_got && (w_got || !ar_valid);
    assign w_ready  = idle && !w_got && (aw_got || !ar_valid);

    assign aw_ok   = aw_got || (aw_valid && aw_ready);
    assign w_ok    = w_got || (w_valid && w_ready);
    assign wr_fire = idle && aw_ok && w_ok;

    // take the latched half if there is one
    assign wr_idx  = aw_got ? awaddr_q[WORD_IDX_W+1:2] : aw_addr[WORD_IDX_W+1:2];
    assign wr_data = w_got ? wdata_q : w_data;
    assign wr_strb = w_got ? wstrb_q : w_strb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= RAM_IDLE;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            case (state)
                RAM_IDLE: begin
                    if (wr_fire) begin
                        state  <= RAM_WR_RESP;   // b_valid next cycle
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                    end else if (ar_valid && ar_ready) begin
                        state <= RAM_RD_RESP;
                    end else begin
                        aw_got <= aw_ok;
                        w_got  <= w_ok;
                    end
                end
                RAM_RD_RESP: if (r_ready) state <= RAM_IDLE;   // held until taken
                RAM_WR_RESP: if (b_ready) state <= RAM_IDLE;
                default:     state <= RAM_IDLE;
            endcase
        end
    end

    // storage and write payload
    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) awaddr_q <= aw_addr;
        if (w_valid && w_ready) begin
            wdata_q <= w_data;
            wstrb_q <= w_strb;
        end
        if (ar_valid && ar_ready) begin
            r_data <= mem[ar_addr[WORD_IDX_W+1:2]];   // upper bits dropped so addresses wrap
        end
        if (wr_fire) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (wr_strb[i]) mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
            end
        end
    end

    assign r_valid = (state == RAM_RD_RESP);
    assign b_valid = (state == RAM_WR_RESP);

endmodule

/* hdl/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // fetch port
    input  logic  inst_ce,
    input  addr_t inst_addr,
    output data_t inst_rdata,
    output logic  inst_rdata_valid,
    // data port
    input  logic  data_ce,
    input  logic  data_we,
    input  addr_t data_addr,
    input  data_t data_wdata,
    input  strb_t data_wmask,
    output data_t data_rdata,
    output logic  data_rdata_valid,
    output logic  data_write_finish
);

    // arbiter to master
    logic  req_valid;
    logic  req_we;
    addr_t req_addr;
    data_t req_wdata;
    strb_t req_strb;
    logic  req_done;
    data_t req_rdata;

    // master to RAM
    logic  ar_valid, ar_ready;
    addr_t ar_addr;
    logic  r_valid, r_ready;
    data_t r_data;
    logic  aw_valid, aw_ready;
    addr_t aw_addr;
    logic  w_valid, w_ready;
    data_t w_data;
    strb_t w_strb;
    logic  b_valid, b_ready;

    sram_port_arbiter u_arbiter (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_ce           (inst_ce),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .inst_rdata_valid  (inst_rdata_valid),
        .data_ce           (data_ce),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_wmask        (data_wmask),
        .data_rdata        (data_rdata),
        .data_rdata_valid  (data_rdata_valid),
        .data_write_finish (data_write_finish),
        .req_valid         (req_valid),
        .req_we            (req_we),
        .req_addr          (req_addr),
        .req_wdata         (req_wdata),
        .req_strb          (req_strb),
        .req_done          (req_done),
        .req_rdata         (req_rdata)
    );

    axi_lite_master u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_strb  (req_strb),
        .req_done  (req_done),
        .req_rdata (req_rdata),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_data    (r_data),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw_addr   (aw_addr),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w_data    (w_data),
        .w_strb    (w_strb),
        .b_valid   (b_valid),
        .b_ready   (b_ready)
    );

    axi_lite_ram u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);   // 8 cycles in reset
        #1 rst_n = 1'b1;   // release away from the edge
    end

endmodule

/* tests/mem_checker.sv */
`timescale 1ns/1ps

module mem_checker
    import mem_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  inst_ce,
    input  addr_t inst_addr,
    input  data_t inst_rdata,
    input  logic  inst_rdata_valid,
    input  logic  data_ce,
    input  logic  data_we,
    input  addr_t data_addr,
    input  data_t data_wdata,
    input  strb_t data_wmask,
    input  data_t data_rdata,
    input  logic  data_rdata_valid,
    input  logic  data_write_finish,
    output int    mismatch_count,
    output int    stray_count
);

    data_t shadow [MEM_WORDS];   // expected RAM image
    logic  known  [MEM_WORDS];   // word fully defined by earlier writes

    initial begin
        mismatch_count = 0;
        stray_count    = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            known[i] = 1'b0;
        end
    end

    // bits 11:2 pick the word and the rest wraps
    function automatic logic [WORD_IDX_W-1:0] word_of(input addr_t addr);
        return addr[11:2];
    endfunction

    function automatic data_t merge_lanes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) result[i*8 +: 8] = new_word[i*8 +: 8];   // only strobed lanes
        end
        return result;
    endfunction

    task automatic check_read(input string port, input addr_t addr, input data_t got);
        logic [WORD_IDX_W-1:0] idx;
        idx = word_of(addr);
        if (!known[idx]) begin
            $display("%0d ns: %s port read word %0d, which was never fully written",
                     $time, port, idx);
            stray_count++;
        end else if (got !== shadow[idx]) begin
            $display("Mismatch at %0d ns: %s read of %h returned %h, expected %h",
                     $time, port, addr, got, shadow[idx]);
            mismatch_count++;
        end
    endtask

    // sampled mid-cycle where pulses and held request fields are stable
    always @(negedge clk) begin
        if (inst_rdata_valid && !inst_ce) begin
            $display("%0d ns: fetch completion pulse with no fetch request", $time);
            stray_count++;
        end
        if ((data_rdata_valid && !(data_ce && !data_we)) ||
            (data_write_finish && !(data_ce && data_we))) begin
            $display("%0d ns: data completion pulse that fits no pending request", $time);
            stray_count++;
        end
        if (rst_n && data_write_finish && data_ce && data_we) begin
            shadow[word_of(data_addr)] = merge_lanes(shadow[word_of(data_addr)],
                                                     data_wdata, data_wmask);
            if (data_wmask == 4'hf) known[word_of(data_addr)] = 1'b1;
        end
        if (rst_n && data_rdata_valid && data_ce) check_read("data", data_addr, data_rdata);
        if (rst_n && inst_rdata_valid && inst_ce) check_read("fetch", inst_addr, inst_rdata);
    end

endmodule

/* tests/mem_subsystem_properties.sv */
`timescale 1ns/1ps

module mem_subsystem_properties
    import mem_bus_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  ar_valid,
    input logic  ar_ready,
    input addr_t ar_addr,
    input logic  r_valid,
    input logic  r_ready,
    input logic  aw_valid,
    input logic  aw_ready,
    input addr_t aw_addr,
    input logic  w_valid,
    input logic  w_ready,
    input logic  b_valid,
    input logic  b_ready,
    input logic  req_done
);

    int fail_count = 0;   // failed assertions so far

    // valid held until its handshake
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid)
        else begin
            fail_count++;
            $error("ar_valid dropped before handshake");
        end
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid)
        else begin
            fail_count++;
            $error("r_valid dropped before handshake");
        end
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid)
        else begin
            fail_count++;
            $error("aw_valid dropped before handshake");
        end
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid)
        else begin
            fail_count++;
            $error("w_valid dropped before handshake");
        end
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid)
        else begin
            fail_count++;
            $error("b_valid dropped before handshake");
        end

    // address frozen while waiting
    ar_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> $stable(ar_addr))
        else begin
            fail_count++;
            $error("ar_addr changed while waiting");
        end
    aw_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> $stable(aw_addr))
        else begin
            fail_count++;
            $error("aw_addr changed while waiting");
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        req_done |=> !req_done)
        else begin
            fail_count++;
            $error("req_done high two cycles in a row");
        end

endmodule

bind axi_lite_master mem_subsystem_properties u_props (.*);

/* tests/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem
    import mem_bus_pkg::*;
;

    localparam logic [1:0] P_INST = 2'd0;
    localparam logic [1:0] P_DATA = 2'd1;
    localparam logic [1:0] P_BOTH = 2'd2;   // data op plus a same-cycle fetch of iaddr
    localparam int N_DIRECTED = 15;
    localparam int N_RANDOM   = 30;
    localparam int WAIT_LIMIT = 200;   // cycles per wait loop

    typedef struct packed {
        logic [1:0] port;
        logic       we;
        addr_t      addr;
        data_t      wdata;
        strb_t      strb;
        addr_t      iaddr;   // fetch side of a P_BOTH entry
    } entry_t;

    // port, we, addr, wdata, strb, iaddr
    entry_t stim_table [N_DIRECTED] = '{
        '{P_DATA, 1'b1, 32'h0000_0100, 32'hdead_beef, 4'hf, 32'h0},
        '{P_DATA, 1'b0, 32'h0000_0100, 32'h0,         4'h0, 32'h0},
        '{P_DATA, 1'b1, 32'h0000_0104, 32'h1122_3344, 4'hf, 32'h0},
        '{P_DATA, 1'b1, 32'h0000_0104, 32'h0000_aa00, 4'h2, 32'h0},   // byte 1 only
        '{P_DATA, 1'b1, 32'h0000_0104, 32'hbb00_0000, 4'h8, 32'h0},   // byte 3 only
        '{P_DATA, 1'b0, 32'h0000_0104, 32'h0,         4'h0, 32'h0},
        '{P_DATA, 1'b1, 32'h0000_0108, 32'h5566_7788, 4'hf, 32'h0},
        '{P_DATA, 1'b1, 32'h0000_0108, 32'hcafe_0000, 4'hc, 32'h0},   // upper half
        '{P_INST, 1'b0, 32'h0000_0108, 32'h0,         4'h0, 32'h0},
        '{P_INST, 1'b0, 32'h7000_0100, 32'h0,         4'h0, 32'h0},   // alias of 0x100
        '{P_DATA, 1'b1, 32'h0001_0204, 32'h0bad_f00d, 4'hf, 32'h0},
        '{P_INST, 1'b0, 32'hffff_f204, 32'h0,         4'h0, 32'h0},
        '{P_BOTH, 1'b1, 32'h0000_010c, 32'h1357_9bdf, 4'hf, 32'h0000_0100},
        '{P_BOTH, 1'b0, 32'h0000_010c, 32'h0,         4'h0, 32'h0000_0104},
        '{P_BOTH, 1'b1, 32'h0000_0100, 32'h0000_0077, 4'h1, 32'h0000_0100}
    };

    logic  clk, rst_n;
    logic  inst_ce, inst_rdata_valid;
    addr_t inst_addr;
    data_t inst_rdata;
    logic  data_ce, data_we, data_rdata_valid, data_write_finish;
    addr_t data_addr;
    data_t data_wdata, data_rdata;
    strb_t data_wmask;
    int    mismatch_count, stray_count;
    int    tb_errors;
    logic  timed_out;
    int    seed = 4395;

    clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    mem_subsystem_top uut (.*);

    mem_checker u_checker (.*);

    // one entry driven 1 ns after an edge and held until each port's pulse
    task automatic apply_entry(input entry_t e);
        logic use_inst, use_data, inst_seen, data_seen;
        int   waited;
        use_inst = (e.port == P_INST) || (e.port == P_BOTH);
        use_data = (e.port == P_DATA) || (e.port == P_BOTH);
        if (use_data) begin
            data_ce    = 1'b1;
            data_we    = e.we;
            data_addr  = e.addr;
            data_wdata = e.wdata;
            data_wmask = e.strb;
        end
        if (use_inst) begin
            inst_ce   = 1'b1;
            inst_addr = (e.port == P_BOTH) ? e.iaddr : e.addr;
        end
        inst_seen = !use_inst;
        data_seen = !use_data;
        waited    = 0;
        while (!(inst_seen && data_seen) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            if (!data_seen && (data_rdata_valid || data_write_finish)) data_seen = 1'b1;
            if (!inst_seen && inst_rdata_valid) begin
                inst_seen = 1'b1;
                if (!data_seen) begin   // data holds the older instruction
                    $display("%0d ns: fetch finished before the data request it tied with",
                             $time);
                    tb_errors++;
                end
            end
            @(posedge clk);
            #1;
            if (data_seen) data_ce = 1'b0;   // drop in the cycle after the pulse
            if (inst_seen) inst_ce = 1'b0;
        end
        if (!(inst_seen && data_seen)) begin
            $display("%0d ns: request at %h got no completion within %0d cycles",
                     $time, e.addr, WAIT_LIMIT);
            tb_errors++;
            timed_out = 1'b1;
            data_ce   = 1'b0;
            inst_ce   = 1'b0;
        end
    endtask

    // random word in a 16 word window at 0x300 with random upper bits
    function automatic addr_t window_addr(input logic [31:0] r);
        return {r[31:12], 12'h300 + {6'd0, r[5:2], 2'b00}};
    endfunction

    initial begin
        entry_t      e;
        logic [31:0] r;
        int          waited;
        inst_ce    = 1'b0;
        inst_addr  = '0;
        data_ce    = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_wmask = '0;
        tb_errors  = 0;
        timed_out  = 1'b0;

        waited = 0;
        while (!rst_n && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            $display("reset never released");
            tb_errors++;
            timed_out = 1'b1;
        end
        repeat (10) @(posedge clk);   // idle window where any pulse is stray
        #1;

        for (int i = 0; i < N_DIRECTED && !timed_out; i++) begin
            apply_entry(stim_table[i]);
        end

        // define the random window before reading it
        for (int i = 0; i < 16 && !timed_out; i++) begin
            r = $random(seed);
            e = '{P_DATA, 1'b1, 32'h300 + 32'(i * 4), r, 4'hf, 32'h0};
            apply_entry(e);
        end
        for (int i = 0; i < N_RANDOM && !timed_out; i++) begin
            r = $random(seed);
            e.port  = (r[1:0] == 2'd3) ? P_DATA : r[1:0];
            e.we    = (e.port != P_INST) && r[2];
            e.strb  = r[7:4];
            e.addr  = window_addr($random(seed));
            e.iaddr = window_addr($random(seed));
            e.wdata = $random(seed);
            apply_entry(e);
        end

        repeat (2) @(posedge clk);
        $display("errors: mismatches=%0d checker=%0d testbench=%0d assertions=%0d",
                 mismatch_count, stray_count, tb_errors, uut.u_master.u_props.fail_count);
        if (mismatch_count + stray_count + tb_errors + uut.u_master.u_props.fail_count == 0)
        begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/mem_bus_pkg.sv
hdl/sram_port_arbiter.sv
hdl/axi_lite_master.sv
hdl/axi_lite_ram.sv
hdl/mem_subsystem_top.sv
tests/clock_gen.sv
tests/mem_checker.sv
tests/mem_subsystem_properties.sv
tests/tb_mem_subsystem.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench
# any variable can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(SIM_BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
